// ==== verilog.f ====
+incdir+hw
hw/ffcp_rx_pkg.sv
hw/ffcp_frame_parser.sv
hw/slot_writer.sv
hw/commit_queue.sv
hw/slot_reader.sv
hw/buffer_arbiter.sv
hw/packet_buffer_ram.sv
hw/ffcp_rx_top.sv
test/ffcp_rx_properties.sv
test/ffcp_rx_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the FFCP receive testbench with Verilator, runs it and checks the log.
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f verilog.f --top-module ffcp_rx_tb \
	--Mdir obj_dir -o ffcp_rx_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/ffcp_rx_sim +verilator+error+limit+100 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "ALL TESTS PASSED" "$log"; then
	exit 0
fi
echo "Pass message not found in $log"
exit 1

// ==== test/ffcp_rx_tb.sv ====
// Randomized testbench for the FFCP receive path.
// A model tracks the slot contents, the commit order and the drop count,
// and every output byte is checked against it as it leaves the DUT.

`timescale 1ns/10ps
`default_nettype none

`include "ffcp_rx_settings.svh"

module ffcp_rx_tb;

	localparam int unsigned PERIOD = 100;
	localparam int unsigned HDR_LEN = `FFCP_ETH_HDR_LEN + 2;
	localparam int unsigned FGP_LEN = `FFCP_FGP_LEN;
	localparam int unsigned NUM_SLOTS = `FFCP_NUM_SLOTS;
	localparam int unsigned TOTAL_FRAMES = 78;
	localparam int unsigned TIMEOUT_CYCLES = 200 * TOTAL_FRAMES + 1000;

	// The first four frame kinds carry payload into the buffer
	localparam int K_GOOD = 0;
	localparam int K_SHORT = 1;
	localparam int K_LONG = 2;
	localparam int K_ERR = 3;
	localparam int K_ETYPE = 4;
	localparam int K_SYN = 5;
	localparam int K_ACK = 6;
	localparam int K_INDEX = 7;

	logic clk;
	logic eth_rx_downstream_rst;
	logic in_valid;
	ffcp_rx_pkg::byte_t in_data;
	logic in_last;
	logic in_err;
	logic in_ready;
	logic out_valid;
	ffcp_rx_pkg::byte_t out_data;
	ffcp_rx_pkg::slot_t out_slot;
	logic out_last;
	logic out_ready;
	ffcp_rx_pkg::drop_count_t drop_count;

	// Model
	ffcp_rx_pkg::byte_t mem_image [NUM_SLOTS][FGP_LEN];
	ffcp_rx_pkg::slot_t exp_slots [$];
	ffcp_rx_pkg::drop_count_t exp_drops;
	int unsigned out_offset;
	int unsigned gap_pct;
	int unsigned test_errors;
	int unsigned tests_passed;
	int unsigned tests_failed;
	int unsigned cycles;

	ffcp_rx_top dut (
		.clk(clk), .eth_rx_downstream_rst(eth_rx_downstream_rst),
		.in_valid(in_valid), .in_data(in_data), .in_last(in_last), .in_err(in_err),
		.in_ready(in_ready), .out_valid(out_valid), .out_data(out_data),
		.out_slot(out_slot), .out_last(out_last), .out_ready(out_ready),
		.drop_count(drop_count));

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	task automatic check_byte(input string name, input ffcp_rx_pkg::byte_t got,
		input ffcp_rx_pkg::byte_t exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_slot(input string name, input ffcp_rx_pkg::slot_t got,
		input ffcp_rx_pkg::slot_t exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s is %0d, expected %0d", $time, name, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_count(input string name, input ffcp_rx_pkg::drop_count_t got,
		input ffcp_rx_pkg::drop_count_t exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s is %0d, expected %0d", $time, name, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s is %b, expected %b", $time, name, got, exp);
			test_errors++;
		end
	endtask

	function automatic bit is_pending(input ffcp_rx_pkg::slot_t s);
		foreach (exp_slots[i])
			if (exp_slots[i] == s)
				return 1'b1;
		return 1'b0;
	endfunction

	function automatic ffcp_rx_pkg::slot_t pick_free_slot();
		ffcp_rx_pkg::slot_t s;
		s = ffcp_rx_pkg::slot_t'($urandom_range(NUM_SLOTS - 1));
		while (is_pending(s))
			s = s + 1'b1;
		return s;
	endfunction

	// Builds one frame of the given kind, sends it and updates the model
	task automatic send_frame(input int kind);
		ffcp_rx_pkg::byte_t frame [$];
		ffcp_rx_pkg::ethertype_t etype;
		ffcp_rx_pkg::slot_t slot;
		int unsigned pay_len;
		int unsigned stall;
		int last;
		bit eligible;
		bit is_payload;
		bit is_commit;
		etype = `FFCP_ETHERTYPE;
		if (kind == K_ETYPE)
			etype = ffcp_rx_pkg::ethertype_t'($urandom_range(16'h88b4));
		slot = pick_free_slot();
		pay_len = FGP_LEN;
		if (kind == K_SHORT)
			pay_len = $urandom_range(FGP_LEN - 1);
		else if (kind == K_LONG)
			pay_len = FGP_LEN + 1 + $urandom_range(7);
		eligible = kind <= K_ERR;
		for (int i = 0; i < 12; i++)
			frame.push_back(ffcp_rx_pkg::byte_t'($urandom));
		frame.push_back(etype[15:8]);
		frame.push_back(etype[7:0]);
		if (kind == K_SYN)
			frame.push_back(ffcp_rx_pkg::byte_t'(ffcp_rx_pkg::SYN));
		else if (kind == K_ACK)
			frame.push_back(ffcp_rx_pkg::byte_t'(ffcp_rx_pkg::ACK));
		else
			frame.push_back(ffcp_rx_pkg::byte_t'(ffcp_rx_pkg::MSG));
		if (kind == K_INDEX)
			frame.push_back(ffcp_rx_pkg::byte_t'(NUM_SLOTS + $urandom_range(255 - NUM_SLOTS)));
		else
			frame.push_back(ffcp_rx_pkg::byte_t'(slot));
		for (int i = 0; i < int'(pay_len); i++)
			frame.push_back(ffcp_rx_pkg::byte_t'($urandom));
		last = frame.size() - 1;
		for (int i = 0; i <= last; i++) begin
			@(negedge clk);
			in_valid = 1'b1;
			in_data = frame[i];
			in_last = i == last;
			in_err = i == last && kind == K_ERR;
			is_payload = eligible && i >= int'(HDR_LEN) && i < int'(HDR_LEN + FGP_LEN);
			is_commit = kind == K_GOOD && i == last;
			stall = 0;
			@(posedge clk);
			// Arbitration may cost a payload byte one cycle and only a commit byte waits longer
			while (in_ready !== 1'b1) begin
				if ((!is_payload && stall == 0) || (is_payload && !is_commit && stall == 1)) begin
					$display("in_ready stalled byte %0d of a frame at %0t where no stall is allowed",
						i, $time);
					test_errors++;
				end
				stall++;
				@(posedge clk);
			end
			if (is_payload)
				mem_image[slot][i - int'(HDR_LEN)] = frame[i];
		end
		if (kind == K_GOOD)
			exp_slots.push_back(slot);
		else
			exp_drops++;
	endtask

	// Lets the DUT drain, checks the drop count and reports the test
	task automatic finish_test(input string name);
		@(negedge clk);
		in_valid = 1'b0;
		in_last = 1'b0;
		in_err = 1'b0;
		while (exp_slots.size() != 0)
			@(posedge clk);
		repeat (2) @(posedge clk);
		check_count("drop_count", drop_count, exp_drops);
		if (test_errors == 0) begin
			$display("Test %s: passed", name);
			tests_passed++;
		end else begin
			$display("Test %s: failed with %0d errors", name, test_errors);
			tests_failed++;
		end
		test_errors = 0;
	endtask

	// Random gaps on out_ready, a new value every cycle
	task automatic drive_out_ready();
		forever begin
			@(negedge clk);
			out_ready = $urandom_range(99) >= gap_pct;
		end
	endtask

	always @(posedge clk) begin
		if (!eth_rx_downstream_rst && out_valid && out_ready) begin
			if (exp_slots.size() == 0) begin
				$display("Output byte of slot %0d at %0t while no committed slot is pending",
					out_slot, $time);
				test_errors++;
			end else begin
				check_slot("out_slot", out_slot, exp_slots[0]);
				check_byte("out_data", out_data, mem_image[exp_slots[0]][out_offset]);
				check_flag("out_last", out_last, out_offset == FGP_LEN - 1);
				if (out_offset == FGP_LEN - 1) begin
					void'(exp_slots.pop_front());
					out_offset = 0;
				end else begin
					out_offset++;
				end
			end
		end
	end

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, the DUT stopped moving data", cycles);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		void'($urandom(32'haf18_64cf));
		eth_rx_downstream_rst = 1'b1;
		in_valid = 1'b0;
		in_data = '0;
		in_last = 1'b0;
		in_err = 1'b0;
		out_ready = 1'b0;
		gap_pct = 0;
		exp_drops = '0;
		out_offset = 0;
		test_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		fork
			drive_out_ready();
		join_none
		repeat (16) @(posedge clk);
		@(negedge clk);
		eth_rx_downstream_rst = 1'b0;
		@(posedge clk);

		check_flag("out_valid", out_valid, 1'b0);
		check_flag("in_ready", in_ready, 1'b1);
		finish_test("reset state");

		repeat (12) send_frame(K_GOOD);
		finish_test("good frames in commit order");

		repeat (12) send_frame(K_ETYPE + int'($urandom_range(3)));
		finish_test("bad header frames dropped");

		repeat (24) send_frame(int'($urandom_range(K_ERR)));
		finish_test("short, long and errored frames among good ones");

		gap_pct = 60;
		repeat (30) send_frame(K_GOOD);
		finish_test("output gaps with a full queue");

		if (dut.props.failures != 0) begin
			$display("Test concurrent assertions: failed %0d times", dut.props.failures);
			tests_failed++;
		end
		$display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/ffcp_rx_properties.sv ====
// Protocol assertions on the FFCP receive path, bound into the top level.
// failures counts the assertion failures for the testbench.

`timescale 1ns/10ps
`default_nettype none

module ffcp_rx_properties (
	input wire clk,
	input wire eth_rx_downstream_rst,
	input wire out_valid,
	input wire out_ready,
	input ffcp_rx_pkg::byte_t out_data,
	input ffcp_rx_pkg::slot_t out_slot,
	input wire out_last,
	input wire push,
	input wire full,
	input wire wr_grant,
	input wire rd_grant
);

	int unsigned failures;

	initial failures = 0;

	a_out_hold: assert property (@(posedge clk) disable iff (eth_rx_downstream_rst)
		out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_slot))
	else begin
		failures++;
		$error("Output changed while out_ready was low");
	end

	a_last_valid: assert property (@(posedge clk) disable iff (eth_rx_downstream_rst)
		out_last |-> out_valid)
	else begin
		failures++;
		$error("out_last without out_valid");
	end

	a_push_room: assert property (@(posedge clk) disable iff (eth_rx_downstream_rst)
		push |-> !full)
	else begin
		failures++;
		$error("Push into a full commit queue");
	end

	a_one_grant: assert property (@(posedge clk) disable iff (eth_rx_downstream_rst)
		!(wr_grant && rd_grant))
	else begin
		failures++;
		$error("Writer and reader granted together");
	end

endmodule

bind ffcp_rx_top ffcp_rx_properties props (
	.clk(clk), .eth_rx_downstream_rst(eth_rx_downstream_rst),
	.out_valid(out_valid), .out_ready(out_ready), .out_data(out_data),
	.out_slot(out_slot), .out_last(out_last), .push(push), .full(full),
	.wr_grant(wr_grant), .rd_grant(rd_grant));

`default_nettype wire

// ==== hw/ffcp_rx_top.sv ====
// Top level of the FFCP receive path: parser, slot writer, commit queue,
// buffer arbiter, packet buffer and slot reader wired together.
// Frames enter as a byte stream and committed slots leave as fragments.

`timescale 1ns/10ps
`default_nettype none

module ffcp_rx_top (
	input wire clk,
	input wire eth_rx_downstream_rst,
	input wire in_valid,
	input ffcp_rx_pkg::byte_t in_data,
	input wire in_last,
	input wire in_err,
	output logic in_ready,
	output logic out_valid,
	output ffcp_rx_pkg::byte_t out_data,
	output ffcp_rx_pkg::slot_t out_slot,
	output logic out_last,
	input wire out_ready,
	output ffcp_rx_pkg::drop_count_t drop_count
);

	// Parser to writer
	logic pay_valid;
	logic pay_ready;
	ffcp_rx_pkg::byte_t pay_data;
	ffcp_rx_pkg::slot_t pay_slot;
	ffcp_rx_pkg::fgp_cnt_t pay_offset;
	logic pay_commit;

	// Queue
	logic push;
	ffcp_rx_pkg::slot_t push_slot;
	logic pop;
	logic full;
	logic empty;
	ffcp_rx_pkg::slot_t head_slot;

	// Buffer access
	logic wr_req;
	logic wr_grant;
	ffcp_rx_pkg::buf_addr_t wr_addr;
	ffcp_rx_pkg::byte_t wr_data;
	logic rd_req;
	logic rd_grant;
	ffcp_rx_pkg::buf_addr_t rd_addr;
	logic ram_en;
	logic ram_we;
	ffcp_rx_pkg::buf_addr_t ram_addr;
	ffcp_rx_pkg::byte_t ram_wdata;
	ffcp_rx_pkg::byte_t rdata;

	ffcp_frame_parser parser (
		.clk(clk), .eth_rx_downstream_rst(eth_rx_downstream_rst),
		.in_valid(in_valid), .in_data(in_data), .in_last(in_last), .in_err(in_err),
		.pay_ready(pay_ready), .in_ready(in_ready),
		.pay_valid(pay_valid), .pay_data(pay_data), .pay_slot(pay_slot),
		.pay_offset(pay_offset), .pay_commit(pay_commit), .drop_count(drop_count));

	slot_writer writer (
		.clk(clk), .eth_rx_downstream_rst(eth_rx_downstream_rst),
		.pay_valid(pay_valid), .pay_data(pay_data), .pay_slot(pay_slot),
		.pay_offset(pay_offset), .pay_commit(pay_commit),
		.wr_grant(wr_grant), .full(full), .pay_ready(pay_ready),
		.wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data),
		.push(push), .push_slot(push_slot));

	commit_queue queue (
		.clk(clk), .eth_rx_downstream_rst(eth_rx_downstream_rst),
		.push(push), .push_slot(push_slot), .pop(pop),
		.full(full), .empty(empty), .head_slot(head_slot));

	buffer_arbiter arbiter (
		.clk(clk), .eth_rx_downstream_rst(eth_rx_downstream_rst),
		.wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data),
		.rd_req(rd_req), .rd_addr(rd_addr),
		.wr_grant(wr_grant), .rd_grant(rd_grant),
		.ram_en(ram_en), .ram_we(ram_we), .ram_addr(ram_addr), .ram_wdata(ram_wdata));

	packet_buffer_ram ram (
		.clk(clk), .eth_rx_downstream_rst(eth_rx_downstream_rst),
		.ram_en(ram_en), .ram_we(ram_we), .ram_addr(ram_addr),
		.ram_wdata(ram_wdata), .rdata(rdata));

	slot_reader reader (
		.clk(clk), .eth_rx_downstream_rst(eth_rx_downstream_rst),
		.empty(empty), .head_slot(head_slot),
		.rd_grant(rd_grant), .rdata(rdata), .out_ready(out_ready),
		.pop(pop), .rd_req(rd_req), .rd_addr(rd_addr),
		.out_valid(out_valid), .out_data(out_data), .out_slot(out_slot),
		.out_last(out_last));

endmodule

`default_nettype wire

// ==== hw/packet_buffer_ram.sv ====
// Single-port byte memory holding one fragment per slot.
// A read returns rdata on the next cycle; writes leave rdata alone.

`timescale 1ns/10ps
`default_nettype none

`include "ffcp_rx_settings.svh"

module packet_buffer_ram (
	input wire clk,
	input wire eth_rx_downstream_rst,
	input wire ram_en,
	input wire ram_we,
	input ffcp_rx_pkg::buf_addr_t ram_addr,
	input ffcp_rx_pkg::byte_t ram_wdata,
	output ffcp_rx_pkg::byte_t rdata
);

	localparam int unsigned SIZE = `FFCP_NUM_SLOTS * `FFCP_FGP_LEN;

	ffcp_rx_pkg::byte_t mem [SIZE];

	always_ff @(posedge clk) begin
		if (ram_en && ram_we)
			mem[ram_addr] <= ram_wdata;
	end

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst)
			rdata <= '0;
		else if (ram_en && !ram_we)
			rdata <= mem[ram_addr];
	end

endmodule

`default_nettype wire

// ==== hw/buffer_arbiter.sv ====
// Shares the single RAM port between the slot writer and the slot reader.
// Grants are combinational; on a tie the side that lost last time wins.

`timescale 1ns/10ps
`default_nettype none

module buffer_arbiter (
	input wire clk,
	input wire eth_rx_downstream_rst,
	input wire wr_req,
	input ffcp_rx_pkg::buf_addr_t wr_addr,
	input ffcp_rx_pkg::byte_t wr_data,
	input wire rd_req,
	input ffcp_rx_pkg::buf_addr_t rd_addr,
	output logic wr_grant,
	output logic rd_grant,
	output logic ram_en,
	output logic ram_we,
	output ffcp_rx_pkg::buf_addr_t ram_addr,
	output ffcp_rx_pkg::byte_t ram_wdata
);

	// High when the writer held the port last
	logic last_wr;

	assign wr_grant = wr_req && (!rd_req || !last_wr);
	assign rd_grant = rd_req && !wr_grant;

	assign ram_en = wr_grant || rd_grant;
	assign ram_we = wr_grant;
	assign ram_addr = wr_grant ? wr_addr : rd_addr;
	assign ram_wdata = wr_data;

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst)
			last_wr <= 1'b0;
		else if (wr_grant)
			last_wr <= 1'b1;
		else if (rd_grant)
			last_wr <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== hw/slot_reader.sv ====
// Takes committed slots from the queue and streams each one out as a fragment.
// One byte is in flight at a time: grant, read data, then hold until out_ready.

`timescale 1ns/10ps
`default_nettype none

`include "ffcp_rx_settings.svh"

module slot_reader (
	input wire clk,
	input wire eth_rx_downstream_rst,
	input wire empty,
	input ffcp_rx_pkg::slot_t head_slot,
	input wire rd_grant,
	input ffcp_rx_pkg::byte_t rdata,
	input wire out_ready,
	output logic pop,
	output logic rd_req,
	output ffcp_rx_pkg::buf_addr_t rd_addr,
	output logic out_valid,
	output ffcp_rx_pkg::byte_t out_data,
	output ffcp_rx_pkg::slot_t out_slot,
	output logic out_last
);

	ffcp_rx_pkg::reader_state_t state;
	ffcp_rx_pkg::slot_t cur_slot;
	ffcp_rx_pkg::fgp_cnt_t offset;
	logic last_offset;

	assign last_offset = offset == ffcp_rx_pkg::fgp_cnt_t'(`FFCP_FGP_LEN - 1);

	assign pop = state == ffcp_rx_pkg::IDLE && !empty;
	assign rd_req = state == ffcp_rx_pkg::READ;
	assign rd_addr = {cur_slot, offset};
	assign out_valid = state == ffcp_rx_pkg::SEND;
	assign out_slot = cur_slot;
	assign out_last = out_valid && last_offset;

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			state <= ffcp_rx_pkg::IDLE;
			offset <= '0;
		end else begin
			case (state)
				ffcp_rx_pkg::IDLE: begin
					if (!empty) begin
						offset <= '0;
						state <= ffcp_rx_pkg::READ;
					end
				end
				ffcp_rx_pkg::READ: begin
					if (rd_grant)
						state <= ffcp_rx_pkg::WAIT;
				end
				// RAM data arrives the cycle after the grant
				ffcp_rx_pkg::WAIT: state <= ffcp_rx_pkg::SEND;
				default: begin
					if (out_ready) begin
						if (last_offset) begin
							state <= ffcp_rx_pkg::IDLE;
						end else begin
							offset <= offset + 1'b1;
							state <= ffcp_rx_pkg::READ;
						end
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (pop)
			cur_slot <= head_slot;
		if (state == ffcp_rx_pkg::WAIT)
			out_data <= rdata;
	end

endmodule

`default_nettype wire

// ==== hw/commit_queue.sv ====
// FIFO of committed slot numbers between the slot writer and the slot reader.
// head_slot shows the oldest entry whenever empty is low.

`timescale 1ns/10ps
`default_nettype none

`include "ffcp_rx_settings.svh"

module commit_queue (
	input wire clk,
	input wire eth_rx_downstream_rst,
	input wire push,
	input ffcp_rx_pkg::slot_t push_slot,
	input wire pop,
	output logic full,
	output logic empty,
	output ffcp_rx_pkg::slot_t head_slot
);

	localparam int unsigned DEPTH = `FFCP_QUEUE_DEPTH;

	typedef logic [$clog2(DEPTH)-1:0] ptr_t;
	typedef logic [$clog2(DEPTH+1)-1:0] count_t;

	ffcp_rx_pkg::slot_t entries [DEPTH];
	ptr_t wr_ptr;
	ptr_t rd_ptr;
	count_t count;
	logic do_push;
	logic do_pop;

	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	assign full = count == count_t'(DEPTH);
	assign empty = count == '0;
	assign head_slot = entries[rd_ptr];

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			entries[wr_ptr] <= push_slot;
	end

endmodule

`default_nettype wire

// ==== hw/slot_writer.sv ====
// Writes payload bytes into the packet buffer through the arbiter.
// A byte is accepted in the cycle it is granted; the byte that ends a good frame
// is held back while the commit queue is full and its slot is pushed one cycle later.

`timescale 1ns/10ps
`default_nettype none

module slot_writer (
	input wire clk,
	input wire eth_rx_downstream_rst,
	input wire pay_valid,
	input ffcp_rx_pkg::byte_t pay_data,
	input ffcp_rx_pkg::slot_t pay_slot,
	input ffcp_rx_pkg::fgp_cnt_t pay_offset,
	input wire pay_commit,
	input wire wr_grant,
	input wire full,
	output logic pay_ready,
	output logic wr_req,
	output ffcp_rx_pkg::buf_addr_t wr_addr,
	output ffcp_rx_pkg::byte_t wr_data,
	output logic push,
	output ffcp_rx_pkg::slot_t push_slot
);

	logic commit_blocked;

	assign commit_blocked = pay_commit && full;

	// No request while blocked, so the reader can drain the queue
	assign wr_req = pay_valid && !commit_blocked;
	assign wr_addr = {pay_slot, pay_offset};
	assign wr_data = pay_data;
	assign pay_ready = wr_grant;

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst)
			push <= 1'b0;
		else
			push <= pay_ready && pay_commit;
	end

	always_ff @(posedge clk) begin
		if (pay_ready && pay_commit)
			push_slot <= pay_slot;
	end

endmodule

`default_nettype wire

// ==== hw/ffcp_frame_parser.sv ====
// Walks the Ethernet and FFCP header of each incoming frame and decides if
// the frame may commit. Payload bytes of eligible frames go to the slot writer
// with their slot and offset; every rejected frame bumps drop_count.

`timescale 1ns/10ps
`default_nettype none

`include "ffcp_rx_settings.svh"

module ffcp_frame_parser (
	input wire clk,
	input wire eth_rx_downstream_rst,
	input wire in_valid,
	input ffcp_rx_pkg::byte_t in_data,
	input wire in_last,
	input wire in_err,
	input wire pay_ready,
	output logic in_ready,
	output logic pay_valid,
	output ffcp_rx_pkg::byte_t pay_data,
	output ffcp_rx_pkg::slot_t pay_slot,
	output ffcp_rx_pkg::fgp_cnt_t pay_offset,
	output logic pay_commit,
	output ffcp_rx_pkg::drop_count_t drop_count
);

	// Ethernet header plus the FFCP type and index bytes
	localparam int unsigned HDR_LEN = `FFCP_ETH_HDR_LEN + 2;
	localparam int unsigned TYPE_POS = `FFCP_ETH_HDR_LEN;

	typedef logic [$clog2(HDR_LEN)-1:0] hdr_cnt_t;

	ffcp_rx_pkg::parser_state_t state;
	hdr_cnt_t hdr_cnt;
	ffcp_rx_pkg::fgp_cnt_t pay_cnt;
	ffcp_rx_pkg::ethertype_t ethertype;
	ffcp_rx_pkg::ffcp_type_t ftype;
	ffcp_rx_pkg::slot_t slot;
	logic in_fire;
	logic hdr_ok;
	logic pay_full;

	assign in_fire = in_valid && in_ready;
	assign pay_full = pay_cnt == ffcp_rx_pkg::fgp_cnt_t'(`FFCP_FGP_LEN - 1);

	// Checked while the index byte itself is on in_data
	assign hdr_ok = ethertype == `FFCP_ETHERTYPE && ftype == ffcp_rx_pkg::MSG &&
		in_data < `FFCP_NUM_SLOTS;

	// Header and discarded bytes never stall
	assign in_ready = (state == ffcp_rx_pkg::PAYLOAD) ? pay_ready : 1'b1;

	assign pay_valid = in_valid && state == ffcp_rx_pkg::PAYLOAD;
	assign pay_data = in_data;
	assign pay_slot = slot;
	assign pay_offset = pay_cnt;
	assign pay_commit = pay_valid && in_last && !in_err && pay_full;

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			state <= ffcp_rx_pkg::HEADER;
			hdr_cnt <= '0;
			pay_cnt <= '0;
			drop_count <= '0;
		end else if (in_fire) begin
			case (state)
				ffcp_rx_pkg::HEADER: begin
					if (in_last) begin
						// Frame ended inside the header
						drop_count <= drop_count + 1'b1;
						hdr_cnt <= '0;
					end else if (hdr_cnt == hdr_cnt_t'(HDR_LEN - 1)) begin
						hdr_cnt <= '0;
						pay_cnt <= '0;
						state <= hdr_ok ? ffcp_rx_pkg::PAYLOAD : ffcp_rx_pkg::DISCARD;
					end else begin
						hdr_cnt <= hdr_cnt + 1'b1;
					end
				end
				ffcp_rx_pkg::PAYLOAD: begin
					if (in_last) begin
						state <= ffcp_rx_pkg::HEADER;
						if (!pay_commit)
							drop_count <= drop_count + 1'b1;
					end else if (pay_full) begin
						// Too long so the rest of the frame is thrown away
						state <= ffcp_rx_pkg::DISCARD;
					end else begin
						pay_cnt <= pay_cnt + 1'b1;
					end
				end
				default: begin
					if (in_last) begin
						drop_count <= drop_count + 1'b1;
						state <= ffcp_rx_pkg::HEADER;
					end
				end
			endcase
		end
	end

	// Header fields, ethertype most significant byte first
	always_ff @(posedge clk) begin
		if (in_fire && state == ffcp_rx_pkg::HEADER) begin
			case (hdr_cnt)
				hdr_cnt_t'(TYPE_POS - 2): ethertype[15:8] <= in_data;
				hdr_cnt_t'(TYPE_POS - 1): ethertype[7:0] <= in_data;
				hdr_cnt_t'(TYPE_POS): ftype <= ffcp_rx_pkg::ffcp_type_t'(in_data);
				hdr_cnt_t'(TYPE_POS + 1): slot <= ffcp_rx_pkg::slot_t'(in_data);
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/ffcp_rx_pkg.sv ====
// Shared types of the FFCP receive path.
// Modules refer to them as ffcp_rx_pkg::name.

`default_nettype none

`include "ffcp_rx_settings.svh"

package ffcp_rx_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [15:0] ethertype_t;
	typedef logic [$clog2(`FFCP_NUM_SLOTS)-1:0] slot_t;
	typedef logic [$clog2(`FFCP_FGP_LEN)-1:0] fgp_cnt_t;
	// Slot number in the upper bits, offset in the lower bits
	typedef logic [$bits(slot_t)+$bits(fgp_cnt_t)-1:0] buf_addr_t;
	typedef logic [15:0] drop_count_t;

	typedef enum logic [7:0] {SYN = 8'd0, MSG = 8'd1, ACK = 8'd2} ffcp_type_t;

	typedef enum logic [1:0] {HEADER, PAYLOAD, DISCARD} parser_state_t;

	typedef enum logic [1:0] {IDLE, READ, WAIT, SEND} reader_state_t;

endpackage

`default_nettype wire

// ==== hw/ffcp_rx_settings.svh ====
// Frame layout, buffer geometry and queue depth of the FFCP receive path.
// Included by the package and by every module that sizes itself from these values.

`ifndef FFCP_RX_SETTINGS_SVH
`define FFCP_RX_SETTINGS_SVH

// Ethernet header bytes ahead of the FFCP type, ethertype at bytes 12 and 13
`define FFCP_ETH_HDR_LEN 14

// Only this ethertype carries FFCP
`define FFCP_ETHERTYPE 16'h88b5

// Payload bytes of one fragment
`define FFCP_FGP_LEN 16

// Slots in the packet buffer
`define FFCP_NUM_SLOTS 16

// Committed slots waiting to be read out
`define FFCP_QUEUE_DEPTH 4

`endif
